/* common/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath widths
`define CPU_WORD_W     32
// pc counts words, not bytes
`define CPU_PC_W       16
`define CPU_REG_SEL_W  5
`define CPU_NUM_REGS   32

// opcodes in instr[31:27]
`define CPU_OP_NOP     5'd0
`define CPU_OP_ADD     5'd1
`define CPU_OP_SUB     5'd2
`define CPU_OP_AND     5'd3
`define CPU_OP_OR      5'd4
`define CPU_OP_XOR     5'd5
`define CPU_OP_ADDI    5'd6
// subtract that sets flags and writes no register
`define CPU_OP_CMP     5'd7
// condition code lives in instr[23:22]
`define CPU_OP_BR      5'd8
`define CPU_OP_JMP     5'd9

// operand forward sources
`define CPU_FWD_RF     2'd0
`define CPU_FWD_EXME   2'd1
`define CPU_FWD_MEWB   2'd2

`endif

/* common/cpu_pkg.sv */
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

    //////////////////////////////////////////////////
    // plain vector types
    typedef logic [`CPU_WORD_W-1:0]    word_t;
    typedef logic [`CPU_PC_W-1:0]      pc_t;
    typedef logic [`CPU_WORD_W-1:0]    instr_t;
    typedef logic [`CPU_REG_SEL_W-1:0] reg_sel_t;
    typedef logic [4:0]                opcode_t;
    // bit 1 is N, bit 0 is Z
    typedef logic [1:0]                flags_t;
    typedef logic [1:0]                cond_t;
    typedef logic [1:0]                fwd_sel_t;

    //////////////////////////////////////////////////
    // stage registers
    // fetch to decode
    typedef struct packed {
        logic   valid;
        pc_t    pc_next;
        instr_t instr;
    } fede_t;

    // decode to execute
    typedef struct packed {
        logic     valid;
        pc_t      pc_next;
        opcode_t  op;
        word_t    reg_1_data;
        word_t    reg_2_data;
        reg_sel_t reg_1_sel;
        reg_sel_t reg_2_sel;
        word_t    imm;
        logic     use_imm;
        logic     reg_wrt_en;
        reg_sel_t reg_wrt_sel;
        logic     branch;
        logic     jump;
        cond_t    cond;
        logic     sets_flags;
    } deex_t;

    // execute to retire
    typedef struct packed {
        logic     valid;
        word_t    alu_out;
        pc_t      pc_target;
        logic     branch;
        logic     jump;
        cond_t    cond;
        flags_t   flags;
        logic     reg_wrt_en;
        reg_sel_t reg_wrt_sel;
    } exme_t;

    // writeback bus that doubles as the mem/wb forward source
    typedef struct packed {
        logic     reg_wrt_en;
        reg_sel_t reg_wrt_sel;
        word_t    data;
    } wb_bus_t;

endpackage

`default_nettype wire

/* logic/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           flush,
    input  cpu_pkg::pc_t   redirect_pc,
    input  cpu_pkg::instr_t instr_data,
    output cpu_pkg::pc_t   instr_addr,
    output cpu_pkg::fede_t fede
);

    import cpu_pkg::*;

    //////////////////////////////////////////////////
    // program counter
    // the pc register is the fetch address itself
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_addr <= '0;
        end else if (flush) begin
            // taken branch or jump from retire
            instr_addr <= redirect_pc;
        end else begin
            instr_addr <= instr_addr + pc_t'(1);
        end
    end

    //////////////////////////////////////////////////
    // fetch/decode register
    always_ff @(posedge clk) begin
        // fetched word and its next pc
        fede.pc_next <= instr_addr + pc_t'(1);
        fede.instr   <= instr_data;
        // word in flight gets squashed on flush
        if (!rst_n) begin
            fede.valid <= 1'b0;
        end else begin
            fede.valid <= !flush;
        end
    end

endmodule

`default_nettype wire

/* decode/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_sel_t rd_sel_1,
    input  cpu_pkg::reg_sel_t rd_sel_2,
    input  cpu_pkg::wb_bus_t  wb,
    output cpu_pkg::word_t    rd_data_1,
    output cpu_pkg::word_t    rd_data_2
);

    import cpu_pkg::*;

    word_t regs [`CPU_NUM_REGS];

    // write port, fed from the writeback bus
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wb.reg_wrt_en) begin
            regs[wb.reg_wrt_sel] <= wb.data;
        end
    end

    // read ports
    // r0 reads zero
    // same-cycle write bypasses the array
    always_comb begin
        if (rd_sel_1 == '0) begin
            rd_data_1 = '0;
        end else if (wb.reg_wrt_en && wb.reg_wrt_sel == rd_sel_1) begin
            rd_data_1 = wb.data;
        end else begin
            rd_data_1 = regs[rd_sel_1];
        end
        if (rd_sel_2 == '0) begin
            rd_data_2 = '0;
        end else if (wb.reg_wrt_en && wb.reg_wrt_sel == rd_sel_2) begin
            rd_data_2 = wb.data;
        end else begin
            rd_data_2 = regs[rd_sel_2];
        end
    end

endmodule

`default_nettype wire

/* decode/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module decode_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  cpu_pkg::fede_t   fede,
    input  cpu_pkg::wb_bus_t wb,
    output cpu_pkg::deex_t   deex
);

    import cpu_pkg::*;

    reg_sel_t rd;
    reg_sel_t rs1;
    reg_sel_t rs2;
    word_t    rd_data_1;
    word_t    rd_data_2;
    deex_t    dec;

    // instruction fields
    assign rd  = fede.instr[26:22];
    assign rs1 = fede.instr[21:17];
    assign rs2 = fede.instr[16:12];

    reg_file reg_file_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_sel_1  (rs1),
        .rd_sel_2  (rs2),
        .wb        (wb),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2)
    );

    //////////////////////////////////////////////////
    // control decode
    always_comb begin
        dec             = '0;
        dec.valid       = fede.valid;
        dec.pc_next     = fede.pc_next;
        dec.op          = fede.instr[31:27];
        dec.reg_1_data  = rd_data_1;
        dec.reg_2_data  = rd_data_2;
        dec.reg_1_sel   = rs1;
        dec.reg_2_sel   = rs2;
        // sign extend imm16
        dec.imm         = {{16{fede.instr[15]}}, fede.instr[15:0]};
        dec.reg_wrt_sel = rd;
        // branch condition sits in the low rd bits
        dec.cond        = fede.instr[23:22];
        case (dec.op)
            `CPU_OP_ADD, `CPU_OP_SUB, `CPU_OP_AND, `CPU_OP_OR, `CPU_OP_XOR: begin
                dec.reg_wrt_en = 1'b1;
            end
            `CPU_OP_ADDI: begin
                // rs2 field overlaps imm and is ignored
                dec.reg_wrt_en = 1'b1;
                dec.use_imm    = 1'b1;
            end
            `CPU_OP_CMP: dec.sets_flags = 1'b1;
            `CPU_OP_BR:  dec.branch     = 1'b1;
            `CPU_OP_JMP: dec.jump       = 1'b1;
            default: ;
        endcase
        // r0 is hardwired and never takes a write
        if (rd == '0) begin
            dec.reg_wrt_en = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // decode/execute register
    always_ff @(posedge clk) begin
        deex <= dec;
        // bubble on flush or empty input
        if (!rst_n) begin
            deex.valid <= 1'b0;
        end else begin
            deex.valid <= fede.valid && !flush;
        end
    end

endmodule

`default_nettype wire

/* execute/forwarding_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module forwarding_unit (
    input  cpu_pkg::deex_t    deex,
    input  cpu_pkg::exme_t    exme,
    input  cpu_pkg::wb_bus_t  wb,
    output cpu_pkg::fwd_sel_t fwd_sel_1,
    output cpu_pkg::fwd_sel_t fwd_sel_2
);

    import cpu_pkg::*;

    // exme checked first since it holds the younger write
    // wb enable is already gated by valid in retire
    function automatic fwd_sel_t pick_src(
        input reg_sel_t src,
        input exme_t    exme_in,
        input wb_bus_t  wb_in
    );
        if (exme_in.valid && exme_in.reg_wrt_en && exme_in.reg_wrt_sel == src) begin
            return `CPU_FWD_EXME;
        end else if (wb_in.reg_wrt_en && wb_in.reg_wrt_sel == src) begin
            return `CPU_FWD_MEWB;
        end
        return `CPU_FWD_RF;
    endfunction

    // one select per source operand
    assign fwd_sel_1 = pick_src(deex.reg_1_sel, exme, wb);
    assign fwd_sel_2 = pick_src(deex.reg_2_sel, exme, wb);

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  cpu_pkg::deex_t    deex,
    input  cpu_pkg::fwd_sel_t fwd_sel_1,
    input  cpu_pkg::fwd_sel_t fwd_sel_2,
    input  cpu_pkg::wb_bus_t  wb,
    output cpu_pkg::exme_t    exme
);

    import cpu_pkg::*;

    word_t  op_a;
    word_t  op_b_reg;
    word_t  op_b;
    word_t  alu_out;
    flags_t alu_flags;
    flags_t flag_q;

    // operand source select
    function automatic word_t fwd_pick(
        input fwd_sel_t sel,
        input word_t    rf_val,
        input word_t    exme_val,
        input word_t    wb_val
    );
        case (sel)
            `CPU_FWD_EXME: return exme_val;
            `CPU_FWD_MEWB: return wb_val;
            default:       return rf_val;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // operands
    assign op_a     = fwd_pick(fwd_sel_1, deex.reg_1_data, exme.alu_out, wb.data);
    assign op_b_reg = fwd_pick(fwd_sel_2, deex.reg_2_data, exme.alu_out, wb.data);
    // addi takes the immediate instead of rs2
    assign op_b     = deex.use_imm ? deex.imm : op_b_reg;

    //////////////////////////////////////////////////
    // alu
    always_comb begin
        case (deex.op)
            `CPU_OP_ADD, `CPU_OP_ADDI: alu_out = op_a + op_b;
            `CPU_OP_SUB, `CPU_OP_CMP:  alu_out = op_a - op_b;
            `CPU_OP_AND:               alu_out = op_a & op_b;
            `CPU_OP_OR:                alu_out = op_a | op_b;
            `CPU_OP_XOR:               alu_out = op_a ^ op_b;
            default:                   alu_out = '0;
        endcase
    end

    // N from the sign bit, Z when all zero
    assign alu_flags = {alu_out[`CPU_WORD_W-1], (alu_out == '0)};

    // flag register
    // updates as an unsquashed flag setter leaves execute
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flag_q <= '0;
        end else if (deex.valid && deex.sets_flags && !flush) begin
            flag_q <= alu_flags;
        end
    end

    //////////////////////////////////////////////////
    // execute/memory register
    always_ff @(posedge clk) begin
        exme.alu_out     <= alu_out;
        // branch and jump targets are pc relative
        exme.pc_target   <= deex.pc_next + pc_t'(deex.imm);
        exme.branch      <= deex.branch;
        exme.jump        <= deex.jump;
        exme.cond        <= deex.cond;
        // flags as seen by this instruction
        exme.flags       <= flag_q;
        exme.reg_wrt_en  <= deex.reg_wrt_en;
        exme.reg_wrt_sel <= deex.reg_wrt_sel;
        if (!rst_n) begin
            exme.valid <= 1'b0;
        end else begin
            exme.valid <= deex.valid && !flush;
        end
    end

endmodule

`default_nettype wire

/* logic/retire_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::exme_t   exme,
    output logic             flush,
    output cpu_pkg::pc_t     redirect_pc,
    output cpu_pkg::wb_bus_t wb
);

    import cpu_pkg::*;

    logic cond_met;

    //////////////////////////////////////////////////
    // branch resolution
    // flags[0] is Z, flags[1] is N
    always_comb begin
        case (exme.cond)
            2'd0:    cond_met = exme.flags[0];
            2'd1:    cond_met = !exme.flags[0];
            2'd2:    cond_met = exme.flags[1];
            default: cond_met = !exme.flags[1];
        endcase
    end

    // jump always taken
    // flush squashes fetch, decode and execute
    assign flush       = exme.valid && (exme.jump || (exme.branch && cond_met));
    assign redirect_pc = exme.pc_target;

    //////////////////////////////////////////////////
    // memory/writeback register
    always_ff @(posedge clk) begin
        wb.reg_wrt_sel <= exme.reg_wrt_sel;
        wb.data        <= exme.alu_out;
        // one pulse per retiring write
        if (!rst_n) begin
            wb.reg_wrt_en <= 1'b0;
        end else begin
            wb.reg_wrt_en <= exme.valid && exme.reg_wrt_en;
        end
    end

endmodule

`default_nettype wire

/* logic/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic             clk,
    input  logic             rst_n,
    output cpu_pkg::pc_t     instr_addr,
    input  cpu_pkg::instr_t  instr_data,
    output cpu_pkg::wb_bus_t wb
);

    import cpu_pkg::*;

    // stage registers
    fede_t    fede;
    deex_t    deex;
    exme_t    exme;
    // redirect from retire
    logic     flush;
    pc_t      redirect_pc;
    // operand forward selects
    fwd_sel_t fwd_sel_1;
    fwd_sel_t fwd_sel_2;

    fetch_stage fetch_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .instr_data  (instr_data),
        .instr_addr  (instr_addr),
        .fede        (fede)
    );

    // wb loops back for register writes
    decode_stage decode_stage_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .fede  (fede),
        .wb    (wb),
        .deex  (deex)
    );

    forwarding_unit forwarding_unit_inst (
        .deex      (deex),
        .exme      (exme),
        .wb        (wb),
        .fwd_sel_1 (fwd_sel_1),
        .fwd_sel_2 (fwd_sel_2)
    );

    execute_stage execute_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .deex      (deex),
        .fwd_sel_1 (fwd_sel_1),
        .fwd_sel_2 (fwd_sel_2),
        .wb        (wb),
        .exme      (exme)
    );

    retire_stage retire_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .exme        (exme),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .wb          (wb)
    );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 40 ns period
    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tests/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    import cpu_pkg::*;

    localparam string STIM_FILE = "tests/cpu_stim.txt";
    localparam int IMEM_DEPTH = 256;
    localparam int WB_TIMEOUT = 200;
    localparam int RST_TIMEOUT = 64;
    // idle window after the last expected write
    localparam int QUIET_CYCLES = 20;
    // JMP with offset -1 spins on its own address
    localparam instr_t JMP_SELF = 32'h4800_ffff;

    logic    clk;
    logic    rst_n;
    pc_t     instr_addr;
    instr_t  instr_data;
    wb_bus_t wb;

    // program image and expected writebacks
    instr_t   imem [IMEM_DEPTH];
    bit       loaded [IMEM_DEPTH];
    reg_sel_t exp_sel [$];
    word_t    exp_data [$];
    int       exp_test [$];

    // bookkeeping
    int pass_cnt;
    int fail_cnt;
    int err_cnt;
    int test_errs;
    int active_test;
    bit timed_out;
    bit stim_ok;

    tb_clock_gen tb_clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cpu_top cpu_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .wb         (wb)
    );

    //////////////////////////////////////////////////
    // instruction memory model
    function automatic instr_t fetch_word(input pc_t addr);
        instr_t word;
        word = JMP_SELF;
        if (addr < IMEM_DEPTH) begin
            if (loaded[addr]) begin
                word = imem[addr];
            end
        end
        return word;
    endfunction

    // answer 1 ns after the edge that moved the pc
    always @(posedge clk) begin
        #1 instr_data = fetch_word(instr_addr);
    end

    //////////////////////////////////////////////////
    // compare tasks
    task automatic check_sel(input reg_sel_t exp, input reg_sel_t act);
        if (act !== exp) begin
            $display("ERR wb.reg_wrt_sel: expected 0x%h, got 0x%h (test %0d)",
                     exp, act, active_test);
            test_errs++;
            err_cnt++;
        end
    endtask

    task automatic check_data(input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR wb.data: expected 0x%h, got 0x%h (test %0d)",
                     exp, act, active_test);
            test_errs++;
            err_cnt++;
        end
    endtask

    task automatic check_addr(input pc_t exp, input pc_t act);
        if (act !== exp) begin
            $display("ERR instr_addr: expected 0x%h, got 0x%h (test %0d)",
                     exp, act, active_test);
            test_errs++;
            err_cnt++;
        end
    endtask

    task automatic check_en(input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR wb.reg_wrt_en: expected 0x%h, got 0x%h (test %0d)",
                     exp, act, active_test);
            test_errs++;
            err_cnt++;
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus file
    // P addr word, T n, W sel data
    task automatic load_stim(output bit ok);
        int          fd;
        int          cur_test;
        string       line;
        logic [31:0] f1;
        logic [31:0] f2;
        ok = 1'b0;
        cur_test = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    if ($sscanf(line, "P %h %h", f1, f2) == 2) begin
                        if (f1 < IMEM_DEPTH) begin
                            imem[f1]   = f2;
                            loaded[f1] = 1'b1;
                        end else begin
                            $display("program address %0h is outside the memory", f1);
                            err_cnt++;
                        end
                    end else if ($sscanf(line, "T %d", f1) == 1) begin
                        cur_test = f1;
                    end else if ($sscanf(line, "W %h %h", f1, f2) == 2) begin
                        exp_sel.push_back(reg_sel_t'(f1));
                        exp_data.push_back(f2);
                        exp_test.push_back(cur_test);
                    end
                end
            end
            $fclose(fd);
            ok = (exp_sel.size() > 0);
        end
    endtask

    // close a test and print its line
    task automatic end_test(input int num);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %0d: pass", num);
        end else begin
            fail_cnt++;
            $display("test %0d: fail with %0d errors", num, test_errs);
        end
        test_errs = 0;
    endtask

    //////////////////////////////////////////////////
    // bounded waits
    // wb sampled at the falling edge
    task automatic wait_writeback(output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < WB_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (wb.reg_wrt_en === 1'b1) begin
                seen = 1'b1;
            end
        end
    endtask

    // test 1 checks a quiet bus in reset and pc 0 on release
    task automatic run_reset_test;
        int cycles;
        bit released;
        cycles = 0;
        released = 1'b0;
        active_test = 1;
        while (!released && cycles < RST_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (rst_n === 1'b1) begin
                released = 1'b1;
            end else begin
                check_en(1'b0, wb.reg_wrt_en);
            end
        end
        if (!released) begin
            $display("timeout: test 1 stalled, reset was never released");
            fail_cnt++;
            timed_out = 1'b1;
        end else begin
            // pc presented at the first edge with reset high
            check_addr('0, instr_addr);
            end_test(1);
        end
    endtask

    // match each writeback pulse against the next expected entry
    task automatic run_program;
        int idx;
        bit seen;
        idx = 0;
        while (idx < exp_sel.size() && !timed_out) begin
            active_test = exp_test[idx];
            wait_writeback(seen);
            if (!seen) begin
                $display("timeout: test %0d stalled, writeback %0d never arrived",
                         exp_test[idx], idx);
                fail_cnt++;
                timed_out = 1'b1;
            end else begin
                check_sel(exp_sel[idx], wb.reg_wrt_sel);
                check_data(exp_data[idx], wb.data);
                if (idx + 1 == exp_sel.size() || exp_test[idx + 1] != exp_test[idx]) begin
                    end_test(exp_test[idx]);
                end
                idx++;
            end
        end
    endtask

    // program ends spinning on a jump and writes nothing more
    task automatic check_quiet;
        int cycles;
        cycles = 0;
        while (cycles < QUIET_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (wb.reg_wrt_en !== 1'b0) begin
                $display("unexpected writeback to r%0d after the last expected one",
                         wb.reg_wrt_sel);
                err_cnt++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    initial begin
        instr_data = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        err_cnt = 0;
        test_errs = 0;
        active_test = 0;
        timed_out = 1'b0;
        load_stim(stim_ok);
        if (!stim_ok) begin
            $display("stimulus file %s could not be read or has no writebacks", STIM_FILE);
            err_cnt++;
        end else begin
            run_reset_test;
            if (!timed_out) begin
                run_program;
            end
            if (!timed_out) begin
                check_quiet;
            end
        end
        $display("tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/cpu_stim.txt */
# P addr word : program word at a word address, hex
# T n : opens test n ; W sel data : expected writeback in order, hex
# test 1 (reset) needs no program lines
T 2
P 00 30400005
P 01 3080fffd
P 02 08c22000
P 03 11041000
P 04 19482000
P 05 21824000
P 06 29cc3000
P 07 08021000
P 08 320e8000
W 01 00000005
W 02 fffffffd
W 03 00000002
W 04 fffffff8
W 05 fffffff8
W 06 fffffffd
W 07 ffffffff
W 08 ffff7fff
T 3
P 09 32400010
P 0a 32520001
P 0b 32920100
P 0c 0ad2a000
P 0d 00000000
P 0e 00000000
P 0f 0b169000
W 09 00000010
W 09 00000011
W 0a 00000111
W 0b 00000122
W 0c 00000133
T 4
# cmp r1,r1 gives Z set, N clear
P 10 38021000
P 11 40000003
P 12 35000001
P 13 35400002
P 14 35800003
P 15 35c00041
P 16 40400003
P 17 35000001
P 18 35400002
P 19 35800003
P 1a 35c00042
P 1b 40800003
P 1c 35000001
P 1d 35400002
P 1e 35800003
P 1f 35c00043
P 20 40c00003
P 21 35000001
P 22 35400002
P 23 35800003
P 24 35c00044
# cmp r2,r1 gives N set, Z clear
P 25 38041000
P 26 40000003
P 27 35000001
P 28 35400002
P 29 35800003
P 2a 35c00045
P 2b 40400003
P 2c 35000001
P 2d 35400002
P 2e 35800003
P 2f 35c00046
P 30 40800003
P 31 35000001
P 32 35400002
P 33 35800003
P 34 35c00047
P 35 40c00003
P 36 35000001
P 37 35400002
P 38 35800003
P 39 35c00048
W 17 00000041
W 14 00000001
W 15 00000002
W 16 00000003
W 17 00000042
W 14 00000001
W 15 00000002
W 16 00000003
W 17 00000043
W 17 00000044
W 14 00000001
W 15 00000002
W 16 00000003
W 17 00000045
W 17 00000046
W 17 00000047
W 14 00000001
W 15 00000002
W 16 00000003
W 17 00000048
T 5
# jmp squashes a cmp that would set N
P 3a 38021000
P 3b 48000003
P 3c 38041000
P 3d 35400002
P 3e 35800003
P 3f 36000055
P 40 40000003
P 41 35000001
P 42 35400002
P 43 35800003
P 44 36400066
W 18 00000055
W 19 00000066

/* files.f */
+incdir+common
common/cpu_pkg.sv
logic/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/forwarding_unit.sv
execute/execute_stage.sv
logic/retire_stage.sv
logic/cpu_top.sv
tests/tb_clock_gen.sv
tests/cpu_tb.sv
